// ==== source/pad_consts.svh ====
/* Pad counts, indices and variant codes for the pad-control core.
   Combined pad order is MIO first, then DIO. Variant codes are 2 bits wide. */

`ifndef PAD_CONSTS_SVH
`define PAD_CONSTS_SVH

//////////////////////////////////////////////////
// Pad counts
//////////////////////////////////////////////////
`define PAD_NUM_MIO 8
`define PAD_NUM_DIO 8
`define PAD_NUM_ALL 16
`define PAD_ATTR_W 4

// Pad variants
`define PAD_VAR_BIDIR 2'd0
`define PAD_VAR_INPUT 2'd1
`define PAD_VAR_TOL 2'd2
`define PAD_VAR_OD 2'd3

//////////////////////////////////////////////////
// DIO indices, relative to the DIO bank
//////////////////////////////////////////////////
`define PAD_DIO_USB_N 0
`define PAD_DIO_USB_P 1
`define PAD_DIO_USB_D 2
`define PAD_DIO_USB_DP_PU 3
`define PAD_DIO_SPI_D0 4
`define PAD_DIO_SPI_D1 5
`define PAD_DIO_SPI_CS_L 6
`define PAD_DIO_SPI_CLK 7

// Straps, MIO indices
`define PAD_STRAP0_MIO 4
`define PAD_STRAP1_MIO 5
`define PAD_STRAP_DELAY 3 // Cycles after reset release

`endif

// ==== source/pad_pkg.sv ====
/* Shared packed types of the pad-control core.
   Arrays are indexed in combined order, MIO pads first. */

`include "pad_consts.svh"

package pad_pkg;

  // Attribute field as written by software
  typedef struct packed {
    logic invert;
    logic virt_od_en;
    logic pull_en;
    logic pull_sel;
  } pad_attr_t;

  typedef pad_attr_t [`PAD_NUM_ALL-1:0] pad_attr_arr_t;

  typedef logic [`PAD_NUM_ALL-1:0][1:0] pad_variant_arr_t;

  // Attributes after restriction to the pad variant
  typedef struct packed {
    logic invert;
    logic od;
    logic drive_en;
    logic pull_en;
    logic pull_sel;
  } pad_cfg_t;

  typedef pad_cfg_t [`PAD_NUM_ALL-1:0] pad_cfg_arr_t;

  typedef struct packed {
    logic out;
    logic oe;
    logic pull_en;
    logic pull_sel; // 1 selects pull-up
  } pad_drive_t;

  typedef pad_drive_t [`PAD_NUM_ALL-1:0] pad_drive_arr_t;

  typedef logic [`PAD_NUM_MIO-1:0] mio_vec_t;
  typedef logic [`PAD_NUM_DIO-1:0] dio_vec_t;
  typedef logic [`PAD_NUM_ALL-1:0] all_vec_t;
  typedef logic [1:0] strap_t;

endpackage

// ==== source/pad_attr_decode.sv ====
/* Restricts requested pad attributes to what each pad variant supports.
   Purely combinational. Variant table is fixed at elaboration. */

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_attr_decode import pad_pkg::*; #(
  parameter pad_variant_arr_t Variant = '0
) (
  input  pad_attr_arr_t pad_attr_i,
  output pad_cfg_arr_t  pad_cfg_o
);

  //////////////////////////////////////////////////
  // Per-pad decode
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `PAD_NUM_ALL; i++) begin : gen_pad
    logic is_input;
    logic is_tol;
    logic is_od;

    assign is_input = (Variant[i] == `PAD_VAR_INPUT);
    assign is_tol   = (Variant[i] == `PAD_VAR_TOL);
    assign is_od    = (Variant[i] == `PAD_VAR_OD);

    assign pad_cfg_o[i].invert = pad_attr_i[i].invert;

    // True open-drain pads ignore the virtual OD request
    assign pad_cfg_o[i].od = is_od | pad_attr_i[i].virt_od_en;

    assign pad_cfg_o[i].drive_en = ~is_input; // No output buffer

    // Tolerant and input-only cells have no pull resistors
    assign pad_cfg_o[i].pull_en  = pad_attr_i[i].pull_en & ~(is_input | is_tol);
    assign pad_cfg_o[i].pull_sel = pad_attr_i[i].pull_sel;
  end

endmodule

// ==== source/pad_drive.sv ====
/* Output path of the pad ring. One register stage between core request and pad.
   Open drain is emulated by driving low only; out is held at 0 on OD pads. */

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_drive import pad_pkg::*; (
  input  logic           clk_main_i,
  input  logic           arst_n_i,
  input  all_vec_t       core_out_i,
  input  all_vec_t       core_oe_i,
  input  pad_cfg_arr_t   pad_cfg_i,
  output pad_drive_arr_t pad_drive_o,
  output logic           usb_dp_pullup_en_o
);

  pad_drive_arr_t drive_d;
  logic           usb_pu_d;

  //////////////////////////////////////////////////
  // Next drive value per pad
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `PAD_NUM_ALL; i++) begin : gen_pad
    logic eff;

    assign eff = core_out_i[i] ^ pad_cfg_i[i].invert; // Value after inversion

    // OD: release the pad for a 1, pull low for a 0
    assign drive_d[i].out = eff & ~pad_cfg_i[i].od;
    assign drive_d[i].oe  = core_oe_i[i] & pad_cfg_i[i].drive_en &
                            ~(pad_cfg_i[i].od & eff);

    assign drive_d[i].pull_en  = pad_cfg_i[i].pull_en;
    assign drive_d[i].pull_sel = pad_cfg_i[i].pull_sel;
  end

  // D+ pull-up taken straight from the core request
  assign usb_pu_d = core_out_i[`PAD_NUM_MIO + `PAD_DIO_USB_DP_PU] &
                    core_oe_i[`PAD_NUM_MIO + `PAD_DIO_USB_DP_PU];

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pad_drive_o        <= '0; // All pads released
      usb_dp_pullup_en_o <= 1'b0;
    end else begin
      pad_drive_o        <= drive_d;
      usb_dp_pullup_en_o <= usb_pu_d;
    end
  end

endmodule

// ==== source/pad_in_sync.sv ====
/* Two-flop synchronizer for a bank of pad inputs. Each bit is synchronized
   on its own, so multi-bit values may be seen torn for one cycle. */

`timescale 1ns/1ps

module pad_in_sync #(
  parameter type payload_t = logic
) (
  input  logic     clk_main_i,
  input  logic     arst_n_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t meta_q; // First stage, may go metastable
  payload_t sync_q;

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

// ==== source/pad_input_overlay.sv ====
/* Input return path after the synchronizers. Data path is combinational.
   Straps are sampled once per reset, PAD_STRAP_DELAY cycles after release. */

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_input_overlay import pad_pkg::*; (
  input  logic         clk_main_i,
  input  logic         arst_n_i,
  input  mio_vec_t     mio_sync_i,
  input  dio_vec_t     dio_sync_i,
  input  pad_cfg_arr_t pad_cfg_i,
  input  logic         usb_rx_en_i,
  output mio_vec_t     mio_in_o,
  output dio_vec_t     dio_in_o,
  output strap_t       strap_o,
  output logic         strap_valid_o
);

  localparam int unsigned cnt_w = $clog2(`PAD_STRAP_DELAY + 1);

  logic             usb_p;
  logic             usb_n;
  logic             diff_d;
  logic             diff_q;
  logic [cnt_w-1:0] strap_cnt_q;

  //////////////////////////////////////////////////
  // Inversion
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `PAD_NUM_MIO; i++) begin : gen_mio
    assign mio_in_o[i] = mio_sync_i[i] ^ pad_cfg_i[i].invert;
  end

  // USB_D carries the receiver output, not the pad value
  for (genvar k = 0; k < `PAD_NUM_DIO; k++) begin : gen_dio
    if (k == `PAD_DIO_USB_D) begin : gen_usb_d
      assign dio_in_o[k] = usb_rx_en_i & diff_d;
    end else begin : gen_plain
      assign dio_in_o[k] = dio_sync_i[k] ^ pad_cfg_i[`PAD_NUM_MIO + k].invert;
    end
  end

  //////////////////////////////////////////////////
  // Differential receiver model
  //////////////////////////////////////////////////

  assign usb_p = dio_sync_i[`PAD_DIO_USB_P];
  assign usb_n = dio_sync_i[`PAD_DIO_USB_N];

  // Equal P and N (SE0 or SE1) keeps the previous bit
  assign diff_d = (usb_p != usb_n) ? usb_p : diff_q;

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      diff_q <= 1'b0;
    end else begin
      diff_q <= diff_d;
    end
  end

  //////////////////////////////////////////////////
  // Strap capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_cnt_q   <= '0;
      strap_valid_o <= 1'b0;
    end else if (!strap_valid_o) begin
      strap_cnt_q <= strap_cnt_q + 1'b1;
      if (strap_cnt_q == cnt_w'(`PAD_STRAP_DELAY - 1)) begin
        strap_valid_o <= 1'b1; // Sticky until next reset
      end
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (!strap_valid_o && strap_cnt_q == cnt_w'(`PAD_STRAP_DELAY - 1)) begin
      strap_o <= {mio_sync_i[`PAD_STRAP1_MIO], mio_sync_i[`PAD_STRAP0_MIO]};
    end
  end

endmodule

// ==== source/pad_ctrl_top.sv ====
/* Pad-control core top. Bidirectional pads are split into drive and input ports.
   Output path has 1 cycle of latency, input path 2 cycles. */

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_ctrl_top import pad_pkg::*; #(
  // Index 15 first, MIO occupies the low half
  parameter pad_variant_arr_t Variant = {
    `PAD_VAR_INPUT, // DIO 7  SPI_CLK
    `PAD_VAR_INPUT, // DIO 6  SPI_CS_L
    `PAD_VAR_BIDIR, // DIO 5  SPI_D1
    `PAD_VAR_BIDIR, // DIO 4  SPI_D0
    `PAD_VAR_BIDIR, // DIO 3  USB_DP_PU
    `PAD_VAR_BIDIR, // DIO 2  USB_D
    `PAD_VAR_TOL,   // DIO 1  USB_P
    `PAD_VAR_TOL,   // DIO 0  USB_N
    `PAD_VAR_OD,    // MIO 7
    `PAD_VAR_OD,    // MIO 6
    {6{`PAD_VAR_BIDIR}} // MIO 5 to 0
  }
) (
  input  logic           clk_main_i,
  input  logic           arst_n_i,
  // Core side
  input  all_vec_t       core_out_i,
  input  all_vec_t       core_oe_i,
  input  pad_attr_arr_t  pad_attr_i,
  input  logic           usb_rx_en_i,
  output mio_vec_t       mio_in_o,
  output dio_vec_t       dio_in_o,
  output strap_t         strap_o,
  output logic           strap_valid_o,
  output logic           usb_dp_pullup_en_o,
  // Pad side
  output pad_drive_arr_t pad_drive_o,
  input  mio_vec_t       mio_pad_i,
  input  dio_vec_t       dio_pad_i
);

  pad_cfg_arr_t pad_cfg;
  mio_vec_t     mio_sync;
  dio_vec_t     dio_sync;

  //////////////////////////////////////////////////
  // Decode, drive, input return
  //////////////////////////////////////////////////

  pad_attr_decode #(
    .Variant ( Variant )
  ) u_pad_attr_decode (
    .pad_attr_i ( pad_attr_i ),
    .pad_cfg_o  ( pad_cfg    )
  );

  pad_drive u_pad_drive (
    .clk_main_i         ( clk_main_i         ),
    .arst_n_i           ( arst_n_i           ),
    .core_out_i         ( core_out_i         ),
    .core_oe_i          ( core_oe_i          ),
    .pad_cfg_i          ( pad_cfg            ),
    .pad_drive_o        ( pad_drive_o        ),
    .usb_dp_pullup_en_o ( usb_dp_pullup_en_o )
  );

  pad_in_sync #(
    .payload_t ( mio_vec_t )
  ) u_mio_sync (
    .clk_main_i ( clk_main_i ),
    .arst_n_i   ( arst_n_i   ),
    .d_i        ( mio_pad_i  ),
    .q_o        ( mio_sync   )
  );

  pad_in_sync #(
    .payload_t ( dio_vec_t )
  ) u_dio_sync (
    .clk_main_i ( clk_main_i ),
    .arst_n_i   ( arst_n_i   ),
    .d_i        ( dio_pad_i  ),
    .q_o        ( dio_sync   )
  );

  pad_input_overlay u_pad_input_overlay (
    .clk_main_i    ( clk_main_i    ),
    .arst_n_i      ( arst_n_i      ),
    .mio_sync_i    ( mio_sync      ),
    .dio_sync_i    ( dio_sync      ),
    .pad_cfg_i     ( pad_cfg       ),
    .usb_rx_en_i   ( usb_rx_en_i   ),
    .mio_in_o      ( mio_in_o      ),
    .dio_in_o      ( dio_in_o      ),
    .strap_o       ( strap_o       ),
    .strap_valid_o ( strap_valid_o )
  );

endmodule

// ==== test/pad_ctrl_checker.sv ====
/* Protocol assertions on the pad side of the top level, attached by bind.
   Needs the same variant table as the bound instance. */

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_ctrl_checker import pad_pkg::*; #(
  parameter pad_variant_arr_t Variant = '0
) (
  input logic           clk_main_i,
  input logic           arst_n_i,
  input pad_drive_arr_t pad_drive_i,
  input logic           strap_valid_i
);

  all_vec_t    oe_vec;
  int unsigned fail_count = 0; // Failed assertions so far

  always_comb begin
    for (int i = 0; i < `PAD_NUM_ALL; i++) begin
      oe_vec[i] = pad_drive_i[i].oe;
    end
  end

  //////////////////////////////////////////////////
  // Per-pad rules
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `PAD_NUM_ALL; i++) begin : gen_pad
    if (Variant[i] == `PAD_VAR_INPUT) begin : gen_input
      a_input_no_oe : assert property (@(posedge clk_main_i) !pad_drive_i[i].oe)
        else begin
          fail_count++;
          $error("Input-only pad %0d has its output enabled", i);
        end
    end else if (Variant[i] == `PAD_VAR_OD) begin : gen_od
      a_od_out_low : assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
                                      pad_drive_i[i].oe |-> !pad_drive_i[i].out)
        else begin
          fail_count++;
          $error("Open-drain pad %0d drives a high level", i);
        end
    end
  end

  a_strap_sticky : assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
                                    strap_valid_i |=> strap_valid_i)
    else begin
      fail_count++;
      $error("strap_valid_o dropped before reset");
    end

  a_reset_no_oe : assert property (@(posedge clk_main_i) !arst_n_i |-> (oe_vec == '0))
    else begin
      fail_count++;
      $error("Output enable set while in reset");
    end

endmodule

bind pad_ctrl_top pad_ctrl_checker #(
  .Variant ( Variant )
) u_pad_ctrl_checker (
  .clk_main_i    ( clk_main_i    ),
  .arst_n_i      ( arst_n_i      ),
  .pad_drive_i   ( pad_drive_o   ),
  .strap_valid_i ( strap_valid_o )
);

// ==== test/pad_ctrl_tb.sv ====
/* Random stimulus on the falling edge, outputs sampled 10 ns after the rising edge.
   Model tracks the 2-flop input pipeline and the USB hold bit on its own. */

`timescale 1ns/1ps

`include "pad_consts.svh"

module pad_ctrl_tb import pad_pkg::*; ();

  localparam int unsigned seed = 32'h0dd3_23de;
  localparam int unsigned strap_wait_max = 20;

  // Default pad table of the top level, index 15 first
  localparam pad_variant_arr_t variant_table = {
    `PAD_VAR_INPUT, `PAD_VAR_INPUT,                               // SPI_CLK, SPI_CS_L
    `PAD_VAR_BIDIR, `PAD_VAR_BIDIR, `PAD_VAR_BIDIR, `PAD_VAR_BIDIR,
    `PAD_VAR_TOL, `PAD_VAR_TOL,                                   // USB_P, USB_N
    `PAD_VAR_OD, `PAD_VAR_OD,                                     // MIO 7, 6
    {6{`PAD_VAR_BIDIR}}
  };

  typedef struct packed {
    pad_drive_arr_t drive;
    logic           usb_pu;
    mio_vec_t       mio_in;
    dio_vec_t       dio_in;
    logic           diff;
  } expect_t;

  logic           clk_main;
  logic           arst_n;
  all_vec_t       core_out;
  all_vec_t       core_oe;
  pad_attr_arr_t  pad_attr;
  logic           usb_rx_en;
  mio_vec_t       mio_pad;
  dio_vec_t       dio_pad;
  mio_vec_t       mio_in;
  dio_vec_t       dio_in;
  strap_t         strap;
  logic           strap_valid;
  logic           usb_dp_pullup_en;
  pad_drive_arr_t pad_drive;

  string    test_name;
  strap_t   strap_held;
  int       check_count;
  int       error_count;
  int       assert_fails; // Concurrent assertion failures in the bound checker
  int       timeout_count;
  int       wait_cycles;
  int       edges;        // Rising edges since reset release
  mio_vec_t mio_meta_m;
  mio_vec_t mio_sync_m;
  dio_vec_t dio_meta_m;
  dio_vec_t dio_sync_m;
  logic     diff_m;
  logic     usb_bit;
  expect_t  exp_v;

  pad_ctrl_top UUT (
    .clk_main_i         ( clk_main         ),
    .arst_n_i           ( arst_n           ),
    .core_out_i         ( core_out         ),
    .core_oe_i          ( core_oe          ),
    .pad_attr_i         ( pad_attr         ),
    .usb_rx_en_i        ( usb_rx_en        ),
    .mio_in_o           ( mio_in           ),
    .dio_in_o           ( dio_in           ),
    .strap_o            ( strap            ),
    .strap_valid_o      ( strap_valid      ),
    .usb_dp_pullup_en_o ( usb_dp_pullup_en ),
    .pad_drive_o        ( pad_drive        ),
    .mio_pad_i          ( mio_pad          ),
    .dio_pad_i          ( dio_pad          )
  );

  always #20 clk_main = ~clk_main;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic expect_t ref_model(all_vec_t c_out, all_vec_t c_oe, pad_attr_arr_t attr,
                                        mio_vec_t mio_s, dio_vec_t dio_s, logic rx_en,
                                        logic diff_prev);
    expect_t e;
    logic    eff;
    logic    od;
    logic    can_drive;
    logic    has_pull;
    int      i;
    e = '0;
    for (i = 0; i < `PAD_NUM_ALL; i++) begin
      od        = (variant_table[i] == `PAD_VAR_OD) | attr[i].virt_od_en;
      can_drive = (variant_table[i] != `PAD_VAR_INPUT);
      has_pull  = (variant_table[i] != `PAD_VAR_INPUT) && (variant_table[i] != `PAD_VAR_TOL);
      eff       = c_out[i] ^ attr[i].invert;
      e.drive[i].out      = od ? 1'b0 : eff;
      e.drive[i].oe       = c_oe[i] & can_drive & ~(od & eff); // OD only pulls low
      e.drive[i].pull_en  = attr[i].pull_en & has_pull;
      e.drive[i].pull_sel = attr[i].pull_sel;
    end
    e.usb_pu = c_out[`PAD_NUM_MIO + `PAD_DIO_USB_DP_PU] & c_oe[`PAD_NUM_MIO + `PAD_DIO_USB_DP_PU];
    for (i = 0; i < `PAD_NUM_MIO; i++) begin
      e.mio_in[i] = mio_s[i] ^ attr[i].invert;
      e.dio_in[i] = dio_s[i] ^ attr[`PAD_NUM_MIO + i].invert;
    end
    // Differential bit holds on SE0 and SE1
    e.diff = (dio_s[`PAD_DIO_USB_P] != dio_s[`PAD_DIO_USB_N]) ? dio_s[`PAD_DIO_USB_P] : diff_prev;
    e.dio_in[`PAD_DIO_USB_D] = rx_en & e.diff;
    return e;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("** Error [%s] expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // Comparison, 10 ns after each rising edge
  //////////////////////////////////////////////////

  always @(posedge clk_main) begin
    #10;
    if (!arst_n) begin
      mio_meta_m = '0;
      mio_sync_m = '0;
      dio_meta_m = '0;
      dio_sync_m = '0;
      diff_m     = 1'b0;
      edges      = 0;
      exp_v      = '0; // Everything released in reset
    end else begin
      mio_sync_m = mio_meta_m; // Pads still hold the values seen at the edge
      mio_meta_m = mio_pad;
      dio_sync_m = dio_meta_m;
      dio_meta_m = dio_pad;
      edges++;
      exp_v  = ref_model(core_out, core_oe, pad_attr, mio_sync_m, dio_sync_m, usb_rx_en, diff_m);
      diff_m = exp_v.diff;
    end
    compare_value({test_name, " pad_drive_o"}, exp_v.drive, pad_drive);
    compare_value({test_name, " usb_dp_pullup_en_o"}, exp_v.usb_pu, usb_dp_pullup_en);
    compare_value({test_name, " mio_in_o"}, exp_v.mio_in, mio_in);
    compare_value({test_name, " dio_in_o"}, exp_v.dio_in, dio_in);
    compare_value({test_name, " strap_valid_o"}, edges >= `PAD_STRAP_DELAY, strap_valid);
    if (edges >= `PAD_STRAP_DELAY) begin
      compare_value({test_name, " strap_o"}, strap_held, strap);
    end
  end

  task automatic randomize_core();
    core_out = $urandom;
    core_oe  = $urandom;
    pad_attr = {$urandom, $urandom};
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    clk_main      = 1'b0;
    arst_n        = 1'b0;
    core_out      = '0;
    core_oe       = '0;
    pad_attr      = '0;
    usb_rx_en     = 1'b0;
    mio_pad       = '0;
    dio_pad       = '0;
    check_count   = 0;
    error_count   = 0;
    assert_fails  = 0;
    timeout_count = 0;
    test_name     = "reset";
    void'($urandom(seed));
    strap_held = $urandom;
    mio_pad[`PAD_STRAP0_MIO] = strap_held[0];
    mio_pad[`PAD_STRAP1_MIO] = strap_held[1];

    repeat (10) @(negedge clk_main);
    arst_n    = 1'b1;
    test_name = "strap";
    for (wait_cycles = 0; wait_cycles < strap_wait_max && !strap_valid; wait_cycles++) begin
      @(negedge clk_main);
    end
    if (!strap_valid) begin
      timeout_count++;
      $display("Timeout: strap_valid_o did not rise within %0d cycles", strap_wait_max);
    end

    if (timeout_count == 0) begin
      test_name = "output";
      repeat (200) begin
        @(negedge clk_main);
        randomize_core();
      end

      test_name = "input";
      repeat (200) begin
        @(negedge clk_main);
        pad_attr  = {$urandom, $urandom};
        mio_pad   = $urandom;
        dio_pad   = $urandom;
        usb_rx_en = $urandom;
      end

      test_name = "usb";
      usb_rx_en = 1'b1;
      repeat (12) begin
        @(negedge clk_main);
        usb_bit = $urandom;
        dio_pad[`PAD_DIO_USB_P] = usb_bit;
        dio_pad[`PAD_DIO_USB_N] = ~usb_bit;
      end
      repeat (6) begin // SE0 or SE1, last bit must hold
        @(negedge clk_main);
        usb_bit = $urandom;
        dio_pad[`PAD_DIO_USB_P] = usb_bit;
        dio_pad[`PAD_DIO_USB_N] = usb_bit;
      end
      @(negedge clk_main);
      usb_rx_en = 1'b0;
      repeat (8) begin
        @(negedge clk_main);
        dio_pad = $urandom;
      end
      repeat (4) @(negedge clk_main); // Drain the input pipeline
    end

    assert_fails = UUT.u_pad_ctrl_checker.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
             check_count, error_count, assert_fails, timeout_count);
    if (error_count == 0 && assert_fails == 0 && timeout_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/pad_pkg.sv
source/pad_attr_decode.sv
source/pad_drive.sv
source/pad_in_sync.sv
source/pad_input_overlay.sv
source/pad_ctrl_top.sv
test/pad_ctrl_checker.sv
test/pad_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: pad_ctrl

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/pad_pkg.sv
      - source/pad_attr_decode.sv
      - source/pad_drive.sv
      - source/pad_in_sync.sv
      - source/pad_input_overlay.sv
      - source/pad_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/pad_ctrl_checker.sv
      - test/pad_ctrl_tb.sv
